// File: verilog/ace_mux_pkg.sv
`default_nettype none

package ace_mux_pkg;

    localparam int unsigned max_slv_ports = 4;
    localparam int unsigned idx_w         = $clog2(max_slv_ports);  // Port index bits
    localparam int unsigned slv_id_w      = 4;
    localparam int unsigned mst_id_w      = slv_id_w + idx_w;       // Prefix on top of upstream ID
    localparam int unsigned addr_w        = 16;
    localparam int unsigned data_w        = 32;
    localparam int unsigned len_w         = 4;                      // Beats minus one

    typedef logic [idx_w-1:0] port_idx_t;

    typedef struct packed {
        logic [slv_id_w-1:0] id;
        logic [addr_w-1:0]   addr;
        logic [len_w-1:0]    len;
    } slv_aw_chan_t;

    typedef struct packed {
        logic [mst_id_w-1:0] id;
        logic [addr_w-1:0]   addr;
        logic [len_w-1:0]    len;
    } mst_aw_chan_t;

    // Shared by upstream and downstream
    typedef struct packed {
        logic [data_w-1:0] data;
        logic              last;
    } w_chan_t;

    typedef struct packed {
        logic [slv_id_w-1:0] id;
        logic [1:0]          resp;
    } slv_b_chan_t;

    typedef struct packed {
        logic [mst_id_w-1:0] id;
        logic [1:0]          resp;
    } mst_b_chan_t;

    typedef struct packed {
        logic [slv_id_w-1:0] id;
        logic [addr_w-1:0]   addr;
        logic [len_w-1:0]    len;
    } slv_ar_chan_t;

    typedef struct packed {
        logic [mst_id_w-1:0] id;
        logic [addr_w-1:0]   addr;
        logic [len_w-1:0]    len;
    } mst_ar_chan_t;

    typedef struct packed {
        logic [slv_id_w-1:0] id;
        logic [data_w-1:0]   data;
        logic [1:0]          resp;
        logic                last;
    } slv_r_chan_t;

    typedef struct packed {
        logic [mst_id_w-1:0] id;
        logic [data_w-1:0]   data;
        logic [1:0]          resp;
        logic                last;
    } mst_r_chan_t;

    typedef struct packed {
        slv_aw_chan_t aw;
        logic         aw_valid;
        w_chan_t      w;
        logic         w_valid;
        logic         b_ready;
        slv_ar_chan_t ar;
        logic         ar_valid;
        logic         r_ready;
        logic         wack;     // One-cycle pulse
        logic         rack;     // One-cycle pulse
    } slv_req_t;

    typedef struct packed {
        logic        aw_ready;
        logic        w_ready;
        slv_b_chan_t b;
        logic        b_valid;
        logic        ar_ready;
        slv_r_chan_t r;
        logic        r_valid;
    } slv_resp_t;

    typedef struct packed {
        mst_aw_chan_t aw;
        logic         aw_valid;
        w_chan_t      w;
        logic         w_valid;
        logic         b_ready;
        mst_ar_chan_t ar;
        logic         ar_valid;
        logic         r_ready;
        logic         wack;
        logic         rack;
    } mst_req_t;

    typedef struct packed {
        logic        aw_ready;
        logic        w_ready;
        mst_b_chan_t b;
        logic        b_valid;
        logic        ar_ready;
        mst_r_chan_t r;
        logic        r_valid;
    } mst_resp_t;

    // Round-robin grant lock
    typedef enum logic {
        arb_idle,
        arb_locked
    } arb_state_e;

endpackage

`default_nettype wire

// File: verilog/idx_fifo.sv
`default_nettype none

module idx_fifo #(
    parameter int unsigned depth = 4
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire logic                   push_i,
    input  wire ace_mux_pkg::port_idx_t data_i,
    input  wire logic                   pop_i,
    output ace_mux_pkg::port_idx_t      data_o,
    output logic                        full_o,
    output logic                        empty_o
);
    import ace_mux_pkg::*;

    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned cnt_w = $clog2(depth + 1);

    port_idx_t        mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;   // Occupancy
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count == cnt_w'(depth));
    assign empty_o = (count == '0);
    assign do_push = push_i && !full_o;   // Refused when full, pop or not
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rr_arbiter.sv
`default_nettype none

module rr_arbiter #(
    parameter int unsigned n = 3
) (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire logic [n-1:0]       req_i,
    input  wire logic               ack_i,    // Handshake of the granted request
    output logic                    gnt_valid_o,
    output ace_mux_pkg::port_idx_t  gnt_idx_o
);
    import ace_mux_pkg::*;

    arb_state_e state_q;
    port_idx_t  last_q;       // Last winner
    port_idx_t  lock_q;       // Held grant
    port_idx_t  pick;
    logic       pick_valid;

    // First requester above the last winner, wrapping around
    always_comb begin
        int unsigned cand;
        pick       = last_q;
        pick_valid = 1'b0;
        for (int unsigned k = 1; k <= n; k++) begin
            cand = (32'(last_q) + k) % n;
            if (!pick_valid && req_i[cand]) begin
                pick       = port_idx_t'(cand);
                pick_valid = 1'b1;
            end
        end
    end

    assign gnt_valid_o = (state_q == arb_locked) ? req_i[lock_q] : pick_valid;
    assign gnt_idx_o   = (state_q == arb_locked) ? lock_q : pick;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= arb_idle;
            last_q  <= port_idx_t'(n - 1);   // So port 0 wins first
            lock_q  <= '0;
        end else begin
            case (state_q)
                arb_idle: begin
                    if (pick_valid && ack_i) begin
                        last_q <= pick;         // Done in one cycle, no lock needed
                    end else if (pick_valid) begin
                        state_q <= arb_locked;
                        lock_q  <= pick;
                    end
                end
                arb_locked: begin
                    if (ack_i) begin
                        state_q <= arb_idle;
                        last_q  <= lock_q;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/axi_mux.sv
`default_nettype none

module axi_mux #(
    parameter int unsigned num_slv_ports = 3,
    parameter int unsigned max_w_trans   = 4
) (
    input  wire logic                                      clk_i,
    input  wire logic                                      rst_i,
    input  wire ace_mux_pkg::slv_req_t [num_slv_ports-1:0] slv_reqs_i,
    output ace_mux_pkg::slv_resp_t     [num_slv_ports-1:0] slv_resps_o,
    output ace_mux_pkg::mst_req_t                          mst_req_o,
    input  wire ace_mux_pkg::mst_resp_t                    mst_resp_i
);
    import ace_mux_pkg::*;

    logic [num_slv_ports-1:0] aw_req;
    logic [num_slv_ports-1:0] ar_req;
    logic                     aw_gnt_valid;
    logic                     ar_gnt_valid;
    port_idx_t                aw_gnt_idx;
    port_idx_t                ar_gnt_idx;
    logic                     aw_valid;
    logic                     aw_hs;
    logic                     ar_hs;
    port_idx_t                w_idx;
    logic                     w_full;
    logic                     w_empty;
    logic                     w_valid;
    logic                     w_last_hs;
    port_idx_t                b_idx;
    port_idx_t                r_idx;

    always_comb begin
        for (int i = 0; i < num_slv_ports; i++) begin
            aw_req[i] = slv_reqs_i[i].aw_valid;
            ar_req[i] = slv_reqs_i[i].ar_valid;
        end
    end

    rr_arbiter #(
        .n (num_slv_ports)
    ) aw_arb (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (aw_req),
        .ack_i       (aw_hs),
        .gnt_valid_o (aw_gnt_valid),
        .gnt_idx_o   (aw_gnt_idx)
    );

    rr_arbiter #(
        .n (num_slv_ports)
    ) ar_arb (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (ar_req),
        .ack_i       (ar_hs),
        .gnt_valid_o (ar_gnt_valid),
        .gnt_idx_o   (ar_gnt_idx)
    );

    assign aw_valid  = aw_gnt_valid && !w_full;   // Hold AW while the W order is full
    assign aw_hs     = aw_valid && mst_resp_i.aw_ready;
    assign ar_hs     = ar_gnt_valid && mst_resp_i.ar_ready;
    assign w_valid   = !w_empty && slv_reqs_i[w_idx].w_valid;
    assign w_last_hs = w_valid && mst_resp_i.w_ready && slv_reqs_i[w_idx].w.last;

    // Port order of granted writes, head owns the W channel
    idx_fifo #(
        .depth (max_w_trans)
    ) w_order_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (aw_hs),
        .data_i  (aw_gnt_idx),
        .pop_i   (w_last_hs),
        .data_o  (w_idx),
        .full_o  (w_full),
        .empty_o (w_empty)
    );

    assign b_idx = mst_resp_i.b.id[slv_id_w +: idx_w];   // Source port from ID prefix
    assign r_idx = mst_resp_i.r.id[slv_id_w +: idx_w];

    always_comb begin
        mst_req_o = '0;   // wack and rack come from the ACE wrapper

        mst_req_o.aw_valid = aw_valid;
        mst_req_o.aw.id    = {aw_gnt_idx, slv_reqs_i[aw_gnt_idx].aw.id};
        mst_req_o.aw.addr  = slv_reqs_i[aw_gnt_idx].aw.addr;
        mst_req_o.aw.len   = slv_reqs_i[aw_gnt_idx].aw.len;

        mst_req_o.w        = slv_reqs_i[w_idx].w;
        mst_req_o.w_valid  = w_valid;

        mst_req_o.ar_valid = ar_gnt_valid;
        mst_req_o.ar.id    = {ar_gnt_idx, slv_reqs_i[ar_gnt_idx].ar.id};
        mst_req_o.ar.addr  = slv_reqs_i[ar_gnt_idx].ar.addr;
        mst_req_o.ar.len   = slv_reqs_i[ar_gnt_idx].ar.len;

        mst_req_o.b_ready  = slv_reqs_i[b_idx].b_ready;
        mst_req_o.r_ready  = slv_reqs_i[r_idx].r_ready;

        for (int i = 0; i < num_slv_ports; i++) begin
            slv_resps_o[i]          = '0;
            slv_resps_o[i].aw_ready = aw_valid && (aw_gnt_idx == port_idx_t'(i))
                                      && mst_resp_i.aw_ready;
            slv_resps_o[i].w_ready  = !w_empty && (w_idx == port_idx_t'(i))
                                      && mst_resp_i.w_ready;
            slv_resps_o[i].ar_ready = ar_gnt_valid && (ar_gnt_idx == port_idx_t'(i))
                                      && mst_resp_i.ar_ready;

            // Responses with the prefix stripped
            slv_resps_o[i].b.id    = mst_resp_i.b.id[slv_id_w-1:0];
            slv_resps_o[i].b.resp  = mst_resp_i.b.resp;
            slv_resps_o[i].b_valid = mst_resp_i.b_valid && (b_idx == port_idx_t'(i));
            slv_resps_o[i].r.id    = mst_resp_i.r.id[slv_id_w-1:0];
            slv_resps_o[i].r.data  = mst_resp_i.r.data;
            slv_resps_o[i].r.resp  = mst_resp_i.r.resp;
            slv_resps_o[i].r.last  = mst_resp_i.r.last;
            slv_resps_o[i].r_valid = mst_resp_i.r_valid && (r_idx == port_idx_t'(i));
        end
    end

endmodule

`default_nettype wire

// File: verilog/ace_mux.sv
`default_nettype none

module ace_mux #(
    parameter int unsigned num_slv_ports  = 3,
    parameter int unsigned max_w_trans    = 4,
    parameter int unsigned max_resp_trans = 4
) (
    input  wire logic                                      clk_i,
    input  wire logic                                      rst_i,
    input  wire ace_mux_pkg::slv_req_t [num_slv_ports-1:0] slv_reqs_i,
    output ace_mux_pkg::slv_resp_t     [num_slv_ports-1:0] slv_resps_o,
    output ace_mux_pkg::mst_req_t                          mst_req_o,
    input  wire ace_mux_pkg::mst_resp_t                    mst_resp_i
);
    import ace_mux_pkg::*;

    mst_req_t  mst_req;    // From the AXI multiplexer
    mst_resp_t mst_resp;   // Into the AXI multiplexer, possibly stalled

    axi_mux #(
        .num_slv_ports (num_slv_ports),
        .max_w_trans   (max_w_trans)
    ) axi_mux_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .slv_reqs_i  (slv_reqs_i),
        .slv_resps_o (slv_resps_o),
        .mst_req_o   (mst_req),
        .mst_resp_i  (mst_resp)
    );

    if (num_slv_ports == 1) begin : gen_single
        always_comb begin
            mst_req_o      = mst_req;
            mst_req_o.wack = slv_reqs_i[0].wack;
            mst_req_o.rack = slv_reqs_i[0].rack;
            mst_resp       = mst_resp_i;
        end
    end else begin : gen_ordered
        port_idx_t b_head;
        port_idx_t r_head;
        logic      b_full;
        logic      b_empty;
        logic      r_full;
        logic      r_empty;
        logic      b_ready;
        logic      r_ready;
        logic      wack;
        logic      rack;

        assign b_ready = mst_req.b_ready && !b_full;   // Stall while the queue is full
        assign r_ready = mst_req.r_ready && !r_full;
        assign wack    = !b_empty && slv_reqs_i[b_head].wack;
        assign rack    = !r_empty && slv_reqs_i[r_head].rack;

        // Completion order of writes
        idx_fifo #(
            .depth (max_resp_trans)
        ) b_order_fifo (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .push_i  (mst_resp_i.b_valid && b_ready),
            .data_i  (mst_resp_i.b.id[slv_id_w +: idx_w]),
            .pop_i   (wack),
            .data_o  (b_head),
            .full_o  (b_full),
            .empty_o (b_empty)
        );

        // Completion order of reads, last beats only
        idx_fifo #(
            .depth (max_resp_trans)
        ) r_order_fifo (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .push_i  (mst_resp_i.r_valid && r_ready && mst_resp_i.r.last),
            .data_i  (mst_resp_i.r.id[slv_id_w +: idx_w]),
            .pop_i   (rack),
            .data_o  (r_head),
            .full_o  (r_full),
            .empty_o (r_empty)
        );

        always_comb begin
            mst_req_o         = mst_req;
            mst_req_o.b_ready = b_ready;
            mst_req_o.r_ready = r_ready;
            mst_req_o.wack    = wack;                          // Head port only
            mst_req_o.rack    = rack;
            mst_resp          = mst_resp_i;
            mst_resp.b_valid  = mst_resp_i.b_valid && !b_full; // Hidden upstream when full
            mst_resp.r_valid  = mst_resp_i.r_valid && !r_full;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ace_mux_top.sv
`default_nettype none

module ace_mux_top #(
    parameter int unsigned num_slv_ports  = 3,
    parameter int unsigned max_w_trans    = 4,   // W order depth
    parameter int unsigned max_resp_trans = 4    // Acknowledge order depth
) (
    input  wire logic                                      clk_i,
    input  wire logic                                      rst_i,
    input  wire ace_mux_pkg::slv_req_t [num_slv_ports-1:0] slv_reqs_i,
    output ace_mux_pkg::slv_resp_t     [num_slv_ports-1:0] slv_resps_o,
    output ace_mux_pkg::mst_req_t                          mst_req_o,
    input  wire ace_mux_pkg::mst_resp_t                    mst_resp_i
);

    ace_mux #(
        .num_slv_ports  (num_slv_ports),
        .max_w_trans    (max_w_trans),
        .max_resp_trans (max_resp_trans)
    ) ace_mux_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .slv_reqs_i  (slv_reqs_i),
        .slv_resps_o (slv_resps_o),
        .mst_req_o   (mst_req_o),
        .mst_resp_i  (mst_resp_i)
    );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned period_ns = 100
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(period_ns / 2);   // Half period
            clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: test/ace_mux_tb.sv
`default_nettype none

module ace_mux_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ace_mux_pkg::*;

    localparam int n_ports        = 3;
    localparam int resp_depth     = 4;
    localparam int timeout_cycles = 200;
    localparam int k_aw           = 0;
    localparam int k_w            = 1;
    localparam int k_b            = 2;
    localparam int k_ar           = 3;
    localparam int k_r            = 4;

    logic                    clk;
    logic                    rst;
    slv_req_t  [n_ports-1:0] slv_reqs;
    slv_resp_t [n_ports-1:0] slv_resps;
    mst_req_t                mst_req;
    mst_resp_t               mst_resp;

    mst_aw_chan_t       wq [$];        // Writes waiting for their data
    mst_b_chan_t        bq [$];
    mst_ar_chan_t       rq [$];
    mst_aw_chan_t       aw_log [$];    // Downstream AW in grant order
    port_idx_t          b_model [$];   // Expected write acknowledge order
    port_idx_t          r_model [$];
    int                 wbeat;
    int                 rbeat;
    bit                 aw_hs;
    bit                 w_hs;
    bit                 b_hs;
    bit                 ar_hs;
    bit                 r_hs;
    mst_aw_chan_t       aw_cap;
    mst_ar_chan_t       ar_cap;
    logic [31:0]        exp_w_data;
    logic               exp_wack;
    logic               exp_rack;
    logic               exp_b_full;
    logic               exp_r_full;
    logic [n_ports-1:0] b_valids;
    logic [n_ports-1:0] r_valids;
    logic [n_ports-1:0] exp_b_valids;
    logic [n_ports-1:0] exp_r_valids;
    logic [31:0]        rng;

    tb_clk_gen #(
        .period_ns (100)
    ) clk_gen_inst (
        .clk_o (clk)
    );

    ace_mux_top #(
        .num_slv_ports  (n_ports),
        .max_w_trans    (4),
        .max_resp_trans (resp_depth)
    ) ace_mux_top_inst (
        .clk_i       (clk),
        .rst_i       (rst),
        .slv_reqs_i  (slv_reqs),
        .slv_resps_o (slv_resps),
        .mst_req_o   (mst_req),
        .mst_resp_i  (mst_resp)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
        $display("ERR %s expected %0h got %0h", name, exp, got);
        abort_run();
    endtask

    task automatic halt_with(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] mem_data(input logic [15:0] a);
        return xorshift32({a, a} ^ 32'd24);
    endfunction

    // Response code follows the address too
    function automatic logic [1:0] mem_resp(input logic [15:0] a);
        return 2'(mem_data(a) >> 30);
    endfunction

    function automatic logic [15:0] rand16();
        rng = xorshift32(rng);
        return rng[15:0];
    endfunction

    // Port and beat number are visible in every write beat
    function automatic logic [31:0] wdata(input int p, input int beat);
        return 32'hD000_0000 | (32'(p) << 16) | 32'(beat);
    endfunction

    function automatic logic port_flag(input int p, input int kind);
        case (kind)
            k_aw:    return slv_resps[p].aw_ready;
            k_w:     return slv_resps[p].w_ready;
            k_b:     return slv_resps[p].b_valid;
            k_ar:    return slv_resps[p].ar_ready;
            default: return slv_resps[p].r_valid;
        endcase
    endfunction

    // Returns just after a falling edge with the flag high
    task automatic wait_port(input int p, input int kind, input string what);
        int n;
        n = 0;
        #1;
        while (!port_flag(p, kind)) begin
            n++;
            if (n > timeout_cycles) begin
                halt_with({"timeout waiting for ", what});
            end
            @(negedge clk);
            #1;
        end
    endtask

    task automatic do_write(input int p, input logic [3:0] wid, input logic [15:0] waddr,
                            input logic [3:0] wlen, input bit get_b);
        @(negedge clk);
        slv_reqs[p].aw.id    = wid;
        slv_reqs[p].aw.addr  = waddr;
        slv_reqs[p].aw.len   = wlen;
        slv_reqs[p].aw_valid = 1'b1;
        wait_port(p, k_aw, "aw_ready");
        @(negedge clk);
        slv_reqs[p].aw_valid = 1'b0;
        for (int b = 0; b <= int'(wlen); b++) begin
            slv_reqs[p].w.data  = wdata(p, b);
            slv_reqs[p].w.last  = (b == int'(wlen));
            slv_reqs[p].w_valid = 1'b1;
            wait_port(p, k_w, "w_ready");
            @(negedge clk);
        end
        slv_reqs[p].w_valid = 1'b0;
        if (get_b) begin
            wait_port(p, k_b, "b_valid");
            assert (slv_resps[p].b.id == wid)
                else mismatch("b.id", wid, slv_resps[p].b.id);
            assert (slv_resps[p].b.resp == mem_resp(waddr))
                else mismatch("b.resp", mem_resp(waddr), slv_resps[p].b.resp);
            @(negedge clk);
        end
    endtask

    task automatic do_read(input int p, input logic [3:0] rid, input logic [15:0] raddr,
                           input logic [3:0] rlen);
        @(negedge clk);
        slv_reqs[p].ar.id    = rid;
        slv_reqs[p].ar.addr  = raddr;
        slv_reqs[p].ar.len   = rlen;
        slv_reqs[p].ar_valid = 1'b1;
        wait_port(p, k_ar, "ar_ready");
        @(negedge clk);
        slv_reqs[p].ar_valid = 1'b0;
        for (int b = 0; b <= int'(rlen); b++) begin
            wait_port(p, k_r, "r_valid");
            assert (slv_resps[p].r.id == rid)
                else mismatch("r.id", rid, slv_resps[p].r.id);
            assert (slv_resps[p].r.data == mem_data(raddr + 16'(b)))
                else mismatch("r.data", mem_data(raddr + 16'(b)), slv_resps[p].r.data);
            assert (slv_resps[p].r.resp == mem_resp(raddr + 16'(b)))
                else mismatch("r.resp", mem_resp(raddr + 16'(b)), slv_resps[p].r.resp);
            assert (slv_resps[p].r.last == (b == int'(rlen)))
                else mismatch("r.last", (b == int'(rlen)), slv_resps[p].r.last);
            @(negedge clk);
        end
    endtask

    task automatic check_aw(input int k, input int p, input logic [3:0] id,
                            input logic [15:0] addr, input logic [3:0] len);
        mst_aw_chan_t exp_aw;
        exp_aw.id   = {port_idx_t'(p), id};   // Source port above the original ID
        exp_aw.addr = addr;
        exp_aw.len  = len;
        assert (aw_log[k] == exp_aw) else mismatch("aw", exp_aw, aw_log[k]);
    endtask

    task automatic pulse_ack(input int p, input bit rd);
        @(negedge clk);
        if (rd) begin
            slv_reqs[p].rack = 1'b1;
        end else begin
            slv_reqs[p].wack = 1'b1;
        end
        #1;
        exp_rack = rd && (r_model.size() != 0) && (int'(r_model[0]) == p);
        exp_wack = !rd && (b_model.size() != 0) && (int'(b_model[0]) == p);
        @(negedge clk);
        slv_reqs[p].rack = 1'b0;
        slv_reqs[p].wack = 1'b0;
        if (exp_rack) begin
            r_model.pop_front();
        end
        if (exp_wack) begin
            b_model.pop_front();
        end
        exp_rack = 1'b0;
        exp_wack = 1'b0;
    endtask

    task automatic drain_acks();
        while (b_model.size() != 0) begin
            pulse_ack(int'(b_model[0]), 1'b0);
        end
        while (r_model.size() != 0) begin
            pulse_ack(int'(r_model[0]), 1'b1);
        end
    endtask

    // Downstream memory model that updates on the falling edge and samples 1 ns later
    always begin
        @(negedge clk);
        if (rst) begin
            wq.delete();
            bq.delete();
            rq.delete();
            aw_log.delete();
            b_model.delete();
            r_model.delete();
            wbeat = 0;
            rbeat = 0;
        end else begin
            if (aw_hs) begin
                wq.push_back(aw_cap);
                aw_log.push_back(aw_cap);
            end
            if (ar_hs) begin
                rq.push_back(ar_cap);
            end
            if (w_hs && wbeat == int'(wq[0].len)) begin
                bq.push_back('{id: wq[0].id, resp: mem_resp(wq[0].addr)});
                void'(wq.pop_front());
                wbeat = 0;
            end else if (w_hs) begin
                wbeat++;
            end
            if (b_hs) begin
                b_model.push_back(bq[0].id[mst_id_w-1 -: idx_w]);
                void'(bq.pop_front());
            end
            if (r_hs && rbeat == int'(rq[0].len)) begin
                r_model.push_back(rq[0].id[mst_id_w-1 -: idx_w]);
                void'(rq.pop_front());
                rbeat = 0;
            end else if (r_hs) begin
                rbeat++;
            end
        end
        mst_resp          = '0;
        mst_resp.aw_ready = 1'b1;
        mst_resp.w_ready  = 1'b1;
        mst_resp.ar_ready = 1'b1;
        mst_resp.b_valid  = (bq.size() != 0);
        if (bq.size() != 0) begin
            mst_resp.b = bq[0];
        end
        mst_resp.r_valid = (rq.size() != 0);
        if (rq.size() != 0) begin
            mst_resp.r.id   = rq[0].id;
            mst_resp.r.data = mem_data(rq[0].addr + 16'(rbeat));
            mst_resp.r.resp = mem_resp(rq[0].addr + 16'(rbeat));
            mst_resp.r.last = (rbeat == int'(rq[0].len));
        end
        #1;
        aw_hs      = !rst && mst_req.aw_valid && mst_resp.aw_ready;
        w_hs       = !rst && mst_req.w_valid && mst_resp.w_ready;
        b_hs       = !rst && mst_resp.b_valid && mst_req.b_ready;
        ar_hs      = !rst && mst_req.ar_valid && mst_resp.ar_ready;
        r_hs       = !rst && mst_resp.r_valid && mst_req.r_ready;
        aw_cap     = mst_req.aw;
        ar_cap     = mst_req.ar;
        exp_b_full = (b_model.size() == resp_depth);
        exp_r_full = (r_model.size() == resp_depth);
        if (w_hs) begin
            assert (wq.size() != 0) else halt_with("write data arrived before its address");
            exp_w_data = wdata(int'(wq[0].id[mst_id_w-1 -: idx_w]), wbeat);
            assert (mst_req.w.data == exp_w_data)
                else mismatch("w.data", exp_w_data, mst_req.w.data);
            assert (mst_req.w.last == (wbeat == int'(wq[0].len)))
                else mismatch("w.last", (wbeat == int'(wq[0].len)), mst_req.w.last);
        end
    end

    always_comb begin
        exp_b_valids = '0;
        exp_r_valids = '0;
        for (int p = 0; p < n_ports; p++) begin
            b_valids[p] = slv_resps[p].b_valid;
            r_valids[p] = slv_resps[p].r_valid;
        end
        if (mst_resp.b_valid && !exp_b_full) begin
            exp_b_valids[mst_resp.b.id[mst_id_w-1 -: idx_w]] = 1'b1;
        end
        if (mst_resp.r_valid && !exp_r_full) begin
            exp_r_valids[mst_resp.r.id[mst_id_w-1 -: idx_w]] = 1'b1;
        end
    end

    // Only the prefix port sees a response and none does while the order queue is full
    b_route: assert property (@(posedge clk) disable iff (rst) b_valids == exp_b_valids)
        else mismatch("b_valid", $sampled(exp_b_valids), $sampled(b_valids));
    r_route: assert property (@(posedge clk) disable iff (rst) r_valids == exp_r_valids)
        else mismatch("r_valid", $sampled(exp_r_valids), $sampled(r_valids));
    b_stall: assert property (@(posedge clk) disable iff (rst) mst_req.b_ready == !exp_b_full)
        else mismatch("b_ready", !$sampled(exp_b_full), $sampled(mst_req.b_ready));
    r_stall: assert property (@(posedge clk) disable iff (rst) mst_req.r_ready == !exp_r_full)
        else mismatch("r_ready", !$sampled(exp_r_full), $sampled(mst_req.r_ready));
    wack_steer: assert property (@(posedge clk) disable iff (rst) mst_req.wack == exp_wack)
        else mismatch("wack", $sampled(exp_wack), $sampled(mst_req.wack));
    rack_steer: assert property (@(posedge clk) disable iff (rst) mst_req.rack == exp_rack)
        else mismatch("rack", $sampled(exp_rack), $sampled(mst_req.rack));

    initial begin
        logic [15:0] a [3];
        int          n;
        slv_reqs = '0;
        for (int p = 0; p < n_ports; p++) begin
            slv_reqs[p].b_ready = 1'b1;
            slv_reqs[p].r_ready = 1'b1;
        end
        mst_resp   = '0;
        exp_wack   = 1'b0;
        exp_rack   = 1'b0;
        exp_b_full = 1'b0;
        exp_r_full = 1'b0;
        rng        = 32'd24;
        rst        = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // All ports request at once and grants go from port 0 upward
        for (int p = 0; p < n_ports; p++) begin
            a[p] = rand16();
        end
        fork
            do_write(0, 4'h1, a[0], 4'd3, 1'b1);
            do_write(1, 4'h2, a[1], 4'd1, 1'b1);
            do_write(2, 4'h3, a[2], 4'd2, 1'b1);
        join
        check_aw(0, 0, 4'h1, a[0], 4'd3);
        check_aw(1, 1, 4'h2, a[1], 4'd1);
        check_aw(2, 2, 4'h3, a[2], 4'd2);
        drain_acks();

        aw_log.delete();
        a[0] = rand16();
        do_write(1, 4'h7, a[0], 4'd2, 1'b1);
        check_aw(0, 1, 4'h7, a[0], 4'd2);
        drain_acks();

        a[0] = rand16();
        a[1] = rand16();
        fork
            do_read(0, 4'h4, a[0], 4'd3);
            do_read(2, 4'h9, a[1], 4'd1);
        join
        drain_acks();

        // Acknowledge from the second port first has no effect
        do_write(2, 4'h5, rand16(), 4'd0, 1'b1);
        do_write(0, 4'h6, rand16(), 4'd1, 1'b1);
        pulse_ack(0, 1'b0);
        pulse_ack(2, 1'b0);
        pulse_ack(0, 1'b0);
        do_read(1, 4'hA, rand16(), 4'd0);
        do_read(2, 4'hB, rand16(), 4'd2);
        pulse_ack(2, 1'b1);
        pulse_ack(1, 1'b1);
        pulse_ack(2, 1'b1);

        // Fill the B order queue so that one more write stalls
        for (int k = 0; k < resp_depth; k++) begin
            do_write(k % n_ports, 4'(k), rand16(), 4'd0, 1'b1);
        end
        do_write(1, 4'hC, rand16(), 4'd0, 1'b0);
        n = 0;
        #1;
        while (!mst_resp.b_valid) begin
            n++;
            if (n > timeout_cycles) begin
                halt_with("timeout waiting for the stalled write response");
            end
            @(negedge clk);
            #1;
        end
        repeat (2) @(negedge clk);
        pulse_ack(0, 1'b0);
        wait_port(1, k_b, "b_valid after the stall");
        assert (slv_resps[1].b.id == 4'hC) else mismatch("b.id", 4'hC, slv_resps[1].b.id);
        @(negedge clk);
        drain_acks();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
verilog/ace_mux_pkg.sv
verilog/idx_fifo.sv
verilog/rr_arbiter.sv
verilog/axi_mux.sv
verilog/ace_mux.sv
verilog/ace_mux_top.sv
test/tb_clk_gen.sv
test/ace_mux_tb.sv

// File: Bender.yml
package:
  name: ace_mux

sources:
  # RTL
  - files:
      - verilog/ace_mux_pkg.sv
      - verilog/idx_fifo.sv
      - verilog/rr_arbiter.sv
      - verilog/axi_mux.sv
      - verilog/ace_mux.sv
      - verilog/ace_mux_top.sv

  # Testbench
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/ace_mux_tb.sv
